// ==== hdl/stout_pkg.sv ====
package stout_pkg;

  // ----------------------------------------
  // widths and counts
  // ----------------------------------------
  localparam int PADDR_W      = 32;            // physical address
  localparam int XLEN_W       = 64;            // store / load data
  localparam int XLEN_B_W     = XLEN_W / 8;    // bytes per load
  localparam int LINE_W       = 128;           // L1D line data
  localparam int LINE_B_W     = LINE_W / 8;    // 16 bytes per line
  localparam int LINE_OFS_W   = $clog2(LINE_B_W);

  localparam int LSU_PORT_NUM = 2;             // load pipeline ports

  // ----------------------------------------
  // L2 request tag
  // ----------------------------------------
  localparam int L2_TAG_W = 4;

  // upper two tag bits mark an L1D write, lower bits stay zero
  localparam logic [1:0] L2_TAG_WR_L1D = 2'b10;

  // ----------------------------------------
  // enums
  // ----------------------------------------
  typedef enum logic [1:0] {
    SIZE_B  = 2'b00,   // 1 byte
    SIZE_H  = 2'b01,   // 2 bytes
    SIZE_W  = 2'b10,   // 4 bytes
    SIZE_DW = 2'b11    // 8 bytes
  } store_size_t;

  typedef enum logic [1:0] {
    CMD_RD = 2'b00,
    CMD_WR = 2'b01
  } l2_cmd_t;

  // arbiter grant, which buffer owns the L2 request
  typedef enum logic {
    SRC_EVICT = 1'b0,
    SRC_UC    = 1'b1
  } req_src_t;

  // same cache line when the bits above the line offset agree
  function automatic logic is_same_line(
    input logic [PADDR_W-1:0] a,
    input logic [PADDR_W-1:0] b
  );
    return a[PADDR_W-1:LINE_OFS_W] == b[PADDR_W-1:LINE_OFS_W];
  endfunction

endpackage

// ==== hdl/evict_buffer.sv ====
`timescale 1ns/1ps

module evict_buffer
  import stout_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,

  input  logic               i_evict_valid,
  output logic               o_evict_ready,
  input  logic [PADDR_W-1:0] i_evict_paddr,
  input  logic [LINE_W-1:0]  i_evict_data,

  input  logic               i_release,
  input  req_src_t           i_grant,

  output logic               o_held_valid,
  output logic [PADDR_W-1:0] o_held_paddr,
  output logic [LINE_W-1:0]  o_held_data
);

  logic w_accept;
  logic w_free;

  assign w_accept = i_evict_valid & o_evict_ready;
  assign w_free   = i_release & (i_grant == SRC_EVICT);   // our turn on L2 done

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_held_valid <= 1'b0;
    end else if (w_accept) begin
      o_held_valid <= 1'b1;
    end else if (w_free) begin
      o_held_valid <= 1'b0;
    end
  end

  // line payload, only loaded on accept
  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      o_held_paddr <= i_evict_paddr;
      o_held_data  <= i_evict_data;
    end
  end

  assign o_evict_ready = !o_held_valid;

  // L2 only takes a line that is actually waiting
  a_release_when_held: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    w_free |-> o_held_valid
  ) else $error("eviction released while the buffer is empty");

endmodule

// ==== hdl/uc_store_buffer.sv ====
`timescale 1ns/1ps

module uc_store_buffer
  import stout_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,

  input  logic                i_uc_valid,
  output logic                o_uc_ready,
  input  logic [PADDR_W-1:0]  i_uc_paddr,
  input  logic [XLEN_W-1:0]   i_uc_data,
  input  store_size_t         i_uc_size,

  input  logic                i_release,
  input  req_src_t            i_grant,

  output logic                o_held_valid,
  output logic [PADDR_W-1:0]  o_held_paddr,
  output logic [LINE_W-1:0]   o_held_data,
  output logic [LINE_B_W-1:0] o_held_be
);

  logic                  w_accept;
  logic                  w_free;
  logic [LINE_OFS_W-1:0] w_ofs;
  logic [LINE_B_W-1:0]   w_size_be;

  assign w_accept = i_uc_valid & o_uc_ready;
  assign w_free   = i_release & (i_grant == SRC_UC);
  assign w_ofs    = i_uc_paddr[LINE_OFS_W-1:0];   // byte offset in line

  // ----------------------------------------
  // size decode, enables at byte 0
  // ----------------------------------------
  always_comb begin
    case (i_uc_size)
      SIZE_B:  w_size_be = LINE_B_W'(8'h01);
      SIZE_H:  w_size_be = LINE_B_W'(8'h03);
      SIZE_W:  w_size_be = LINE_B_W'(8'h0f);
      SIZE_DW: w_size_be = LINE_B_W'(8'hff);
      default: w_size_be = '0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_held_valid <= 1'b0;
    end else if (w_accept) begin
      o_held_valid <= 1'b1;
    end else if (w_free) begin
      o_held_valid <= 1'b0;
    end
  end

  // place enables and data at the line offset
  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      o_held_paddr <= i_uc_paddr;
      o_held_be    <= w_size_be << w_ofs;
      o_held_data  <= {{(LINE_W-XLEN_W){1'b0}}, i_uc_data} << {w_ofs, 3'b000};
    end
  end

  assign o_uc_ready = !o_held_valid;

  // misaligned stores would cross the enable window
  a_natural_align: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    w_accept |-> (i_uc_paddr[2:0] & ~(3'b111 << i_uc_size)) == 3'b000
  ) else $error("UC store not aligned to its size");

endmodule

// ==== hdl/l2_write_arbiter.sv ====
`timescale 1ns/1ps

module l2_write_arbiter
  import stout_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,

  input  logic                i_evict_valid,
  input  logic [PADDR_W-1:0]  i_evict_paddr,
  input  logic [LINE_W-1:0]   i_evict_data,

  input  logic                i_uc_valid,
  input  logic [PADDR_W-1:0]  i_uc_paddr,
  input  logic [LINE_W-1:0]   i_uc_data,
  input  logic [LINE_B_W-1:0] i_uc_be,

  input  logic                i_l2_ready,
  output req_src_t            o_grant,
  output logic                o_release,

  output logic                o_l2_valid,
  output l2_cmd_t             o_l2_cmd,
  output logic [PADDR_W-1:0]  o_l2_addr,
  output logic [L2_TAG_W-1:0] o_l2_tag,
  output logic [LINE_W-1:0]   o_l2_data,
  output logic [LINE_B_W-1:0] o_l2_be
);

  logic r_uc_locked;   // UC already on the bus and stalled

  // evictions win, unless a stalled UC request is already showing
  assign o_grant = (i_uc_valid && (r_uc_locked || !i_evict_valid)) ? SRC_UC : SRC_EVICT;

  assign o_l2_valid = i_evict_valid | i_uc_valid;
  assign o_release  = o_l2_valid & i_l2_ready;   // L2 handshake

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_uc_locked <= 1'b0;
    end else begin
      r_uc_locked <= o_l2_valid & !i_l2_ready & (o_grant == SRC_UC);
    end
  end

  // ----------------------------------------
  // payload mux
  // ----------------------------------------
  always_comb begin
    o_l2_cmd = CMD_WR;
    o_l2_tag = {L2_TAG_WR_L1D, {(L2_TAG_W-2){1'b0}}};
    if (o_grant == SRC_EVICT) begin
      o_l2_addr = i_evict_paddr;
      o_l2_data = i_evict_data;
      o_l2_be   = '1;   // whole line
    end else begin
      o_l2_addr = i_uc_paddr;
      o_l2_data = i_uc_data;
      o_l2_be   = i_uc_be;
    end
  end

  a_l2_stable: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    o_l2_valid && !i_l2_ready |=>
      o_l2_valid && $stable(o_l2_addr) && $stable(o_l2_data) && $stable(o_l2_be)
  ) else $error("L2 payload changed under back-pressure");

endmodule

// ==== hdl/lsu_fwd_checker.sv ====
`timescale 1ns/1ps

module lsu_fwd_checker
  import stout_pkg::*;
(
  input  logic                i_held_valid,
  input  logic [PADDR_W-1:0]  i_held_paddr,
  input  logic [LINE_W-1:0]   i_held_data,

  input  logic                i_fwd_valid [LSU_PORT_NUM],
  input  logic [PADDR_W-1:0]  i_fwd_paddr [LSU_PORT_NUM],
  output logic                o_fwd_hit   [LSU_PORT_NUM],
  output logic [XLEN_B_W-1:0] o_fwd_be    [LSU_PORT_NUM],
  output logic [XLEN_W-1:0]   o_fwd_data  [LSU_PORT_NUM]
);

  // ----------------------------------------
  // one compare per load port
  // ----------------------------------------
  for (genvar p = 0; p < LSU_PORT_NUM; p++) begin : g_port
    logic [LINE_OFS_W-1:0] w_ofs;
    logic [LINE_W-1:0]     w_shifted;

    assign w_ofs = i_fwd_paddr[p][LINE_OFS_W-1:0];

    assign o_fwd_hit[p] = i_held_valid & i_fwd_valid[p] &
                          is_same_line(i_held_paddr, i_fwd_paddr[p]);

    // full dword forwarded, the load picks its bytes
    assign o_fwd_be[p] = {XLEN_B_W{o_fwd_hit[p]}};

    assign w_shifted     = i_held_data >> {w_ofs, 3'b000};
    assign o_fwd_data[p] = w_shifted[XLEN_W-1:0];   // low XLEN of shifted line
  end

endmodule

// ==== hdl/snoop_responder.sv ====
`timescale 1ns/1ps

module snoop_responder
  import stout_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,

  input  logic                i_snp_req_valid,
  input  logic [PADDR_W-1:0]  i_snp_paddr,

  input  logic                i_held_valid,
  input  logic [PADDR_W-1:0]  i_held_paddr,
  input  logic [LINE_W-1:0]   i_held_data,

  output logic                o_snp_resp_valid,
  output logic [LINE_W-1:0]   o_snp_resp_data,
  output logic [LINE_B_W-1:0] o_snp_resp_be
);

  logic w_match;

  // only a line still waiting in the buffer can answer
  assign w_match = i_held_valid & is_same_line(i_held_paddr, i_snp_paddr);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_snp_resp_valid <= 1'b0;
    end else begin
      o_snp_resp_valid <= i_snp_req_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_snp_resp_data <= i_held_data;
    o_snp_resp_be   <= {LINE_B_W{w_match}};   // all or nothing
  end

endmodule

// ==== hdl/store_requestor.sv ====
`timescale 1ns/1ps

module store_requestor
  import stout_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,

  // L1D eviction
  input  logic                i_evict_valid,
  output logic                o_evict_ready,
  input  logic [PADDR_W-1:0]  i_evict_paddr,
  input  logic [LINE_W-1:0]   i_evict_data,

  // uncached store
  input  logic                i_uc_valid,
  output logic                o_uc_ready,
  input  logic [PADDR_W-1:0]  i_uc_paddr,
  input  logic [XLEN_W-1:0]   i_uc_data,
  input  store_size_t         i_uc_size,

  // L2 write request
  output logic                o_l2_valid,
  input  logic                i_l2_ready,
  output l2_cmd_t             o_l2_cmd,
  output logic [PADDR_W-1:0]  o_l2_addr,
  output logic [L2_TAG_W-1:0] o_l2_tag,
  output logic [LINE_W-1:0]   o_l2_data,
  output logic [LINE_B_W-1:0] o_l2_be,

  // load pipeline forward check
  input  logic                i_fwd_valid [LSU_PORT_NUM],
  input  logic [PADDR_W-1:0]  i_fwd_paddr [LSU_PORT_NUM],
  output logic                o_fwd_hit   [LSU_PORT_NUM],
  output logic [XLEN_B_W-1:0] o_fwd_be    [LSU_PORT_NUM],
  output logic [XLEN_W-1:0]   o_fwd_data  [LSU_PORT_NUM],

  // snoop
  input  logic                i_snp_req_valid,
  input  logic [PADDR_W-1:0]  i_snp_paddr,
  output logic                o_snp_resp_valid,
  output logic [LINE_W-1:0]   o_snp_resp_data,
  output logic [LINE_B_W-1:0] o_snp_resp_be
);

  // ----------------------------------------
  // internal wires
  // ----------------------------------------
  logic                evict_held_valid;
  logic [PADDR_W-1:0]  evict_held_paddr;
  logic [LINE_W-1:0]   evict_held_data;

  logic                uc_held_valid;
  logic [PADDR_W-1:0]  uc_held_paddr;
  logic [LINE_W-1:0]   uc_held_data;
  logic [LINE_B_W-1:0] uc_held_be;

  req_src_t            grant;
  logic                release_pulse;   // L2 took the granted entry

  evict_buffer u_evict_buffer (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_evict_valid (i_evict_valid),
    .o_evict_ready (o_evict_ready),
    .i_evict_paddr (i_evict_paddr),
    .i_evict_data  (i_evict_data),
    .i_release     (release_pulse),
    .i_grant       (grant),
    .o_held_valid  (evict_held_valid),
    .o_held_paddr  (evict_held_paddr),
    .o_held_data   (evict_held_data)
  );

  uc_store_buffer u_uc_store_buffer (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_uc_valid   (i_uc_valid),
    .o_uc_ready   (o_uc_ready),
    .i_uc_paddr   (i_uc_paddr),
    .i_uc_data    (i_uc_data),
    .i_uc_size    (i_uc_size),
    .i_release    (release_pulse),
    .i_grant      (grant),
    .o_held_valid (uc_held_valid),
    .o_held_paddr (uc_held_paddr),
    .o_held_data  (uc_held_data),
    .o_held_be    (uc_held_be)
  );

  l2_write_arbiter u_l2_write_arbiter (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_evict_valid (evict_held_valid),
    .i_evict_paddr (evict_held_paddr),
    .i_evict_data  (evict_held_data),
    .i_uc_valid    (uc_held_valid),
    .i_uc_paddr    (uc_held_paddr),
    .i_uc_data     (uc_held_data),
    .i_uc_be       (uc_held_be),
    .i_l2_ready    (i_l2_ready),
    .o_grant       (grant),
    .o_release     (release_pulse),
    .o_l2_valid    (o_l2_valid),
    .o_l2_cmd      (o_l2_cmd),
    .o_l2_addr     (o_l2_addr),
    .o_l2_tag      (o_l2_tag),
    .o_l2_data     (o_l2_data),
    .o_l2_be       (o_l2_be)
  );

  // both checkers look at the waiting eviction only
  lsu_fwd_checker u_lsu_fwd_checker (
    .i_held_valid (evict_held_valid),
    .i_held_paddr (evict_held_paddr),
    .i_held_data  (evict_held_data),
    .i_fwd_valid  (i_fwd_valid),
    .i_fwd_paddr  (i_fwd_paddr),
    .o_fwd_hit    (o_fwd_hit),
    .o_fwd_be     (o_fwd_be),
    .o_fwd_data   (o_fwd_data)
  );

  snoop_responder u_snoop_responder (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_snp_req_valid  (i_snp_req_valid),
    .i_snp_paddr      (i_snp_paddr),
    .i_held_valid     (evict_held_valid),
    .i_held_paddr     (evict_held_paddr),
    .i_held_data      (evict_held_data),
    .o_snp_resp_valid (o_snp_resp_valid),
    .o_snp_resp_data  (o_snp_resp_data),
    .o_snp_resp_be    (o_snp_resp_be)
  );

endmodule

// ==== testbench/tb_store_requestor.sv ====
`timescale 1ns/1ps

module tb_store_requestor
  import stout_pkg::*;
();

  localparam int WAIT_LIMIT = 200;   // cycles before any wait gives up

  logic                i_clk;
  logic                i_reset_n;
  logic                i_evict_valid;
  logic                o_evict_ready;
  logic [PADDR_W-1:0]  i_evict_paddr;
  logic [LINE_W-1:0]   i_evict_data;
  logic                i_uc_valid;
  logic                o_uc_ready;
  logic [PADDR_W-1:0]  i_uc_paddr;
  logic [XLEN_W-1:0]   i_uc_data;
  store_size_t         i_uc_size;
  logic                o_l2_valid;
  logic                i_l2_ready;
  l2_cmd_t             o_l2_cmd;
  logic [PADDR_W-1:0]  o_l2_addr;
  logic [L2_TAG_W-1:0] o_l2_tag;
  logic [LINE_W-1:0]   o_l2_data;
  logic [LINE_B_W-1:0] o_l2_be;
  logic                i_fwd_valid [LSU_PORT_NUM];
  logic [PADDR_W-1:0]  i_fwd_paddr [LSU_PORT_NUM];
  logic                o_fwd_hit   [LSU_PORT_NUM];
  logic [XLEN_B_W-1:0] o_fwd_be    [LSU_PORT_NUM];
  logic [XLEN_W-1:0]   o_fwd_data  [LSU_PORT_NUM];
  logic                i_snp_req_valid;
  logic [PADDR_W-1:0]  i_snp_paddr;
  logic                o_snp_resp_valid;
  logic [LINE_W-1:0]   o_snp_resp_data;
  logic [LINE_B_W-1:0] o_snp_resp_be;

  logic [31:0] lfsr;
  int          err_count;
  int          pass_count;
  int          fail_count;

  store_requestor dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;   // 8 ns period
  end

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // ----------------------------------------
  // reporting and compare tasks
  // ----------------------------------------
  task automatic report_fail(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    err_count++;
  endtask

  task automatic abort_run(input string msg);
    $display("%0t ns: %s, stopping the run", $time, msg);
    $display("TEST FAIL");
    $finish;
  endtask

  task automatic log_result(input int n, input string op, input int errs_before);
    if (err_count == errs_before) begin
      pass_count++;
      $display("test %0d %s passed", n, op);
    end else begin
      fail_count++;
      $display("test %0d %s failed", n, op);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
      report_fail($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic check_l2_req(input l2_cmd_t exp_cmd, input logic [PADDR_W-1:0] exp_addr,
                              input logic [LINE_B_W-1:0] exp_be,
                              input logic [LINE_W-1:0] exp_data);
    if (o_l2_cmd !== exp_cmd)
      report_fail($sformatf("l2 cmd %0d, expected %0d", o_l2_cmd, exp_cmd));
    // upper two bits carry the L1D write mark, the rest stays zero
    if (o_l2_tag[L2_TAG_W-1 -: 2] !== L2_TAG_WR_L1D || o_l2_tag[L2_TAG_W-3:0] !== '0)
      report_fail($sformatf("l2 tag %h, expected upper bits %b and zero below",
                            o_l2_tag, L2_TAG_WR_L1D));
    if (o_l2_addr !== exp_addr)
      report_fail($sformatf("l2 addr %h, expected %h", o_l2_addr, exp_addr));
    if (o_l2_be !== exp_be)
      report_fail($sformatf("l2 be %h, expected %h", o_l2_be, exp_be));
    if (o_l2_data !== exp_data)
      report_fail($sformatf("l2 data %h, expected %h", o_l2_data, exp_data));
  endtask

  task automatic check_fwd(input int p, input logic exp_hit,
                           input logic [XLEN_B_W-1:0] exp_be, input logic [XLEN_W-1:0] exp_data);
    if (o_fwd_hit[p] !== exp_hit)
      report_fail($sformatf("port %0d fwd hit %b, expected %b", p, o_fwd_hit[p], exp_hit));
    if (o_fwd_be[p] !== exp_be)
      report_fail($sformatf("port %0d fwd be %h, expected %h", p, o_fwd_be[p], exp_be));
    if (exp_hit && o_fwd_data[p] !== exp_data)
      report_fail($sformatf("port %0d fwd data %h, expected %h", p, o_fwd_data[p], exp_data));
  endtask

  task automatic check_snoop(input logic [LINE_B_W-1:0] exp_be, input logic [LINE_W-1:0] exp_data);
    check_bit("o_snp_resp_valid", o_snp_resp_valid, 1'b1);
    if (o_snp_resp_be !== exp_be)
      report_fail($sformatf("snoop be %h, expected %h", o_snp_resp_be, exp_be));
    if (|exp_be && o_snp_resp_data !== exp_data)
      report_fail($sformatf("snoop data %h, expected %h", o_snp_resp_data, exp_data));
  endtask

  task automatic check_idle();
    @(negedge i_clk);
    check_bit("o_l2_valid when idle", o_l2_valid, 1'b0);
    check_bit("o_evict_ready when idle", o_evict_ready, 1'b1);
    check_bit("o_uc_ready when idle", o_uc_ready, 1'b1);
    check_bit("o_snp_resp_valid when idle", o_snp_resp_valid, 1'b0);
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  // returns on the edge where the inputs were taken
  task automatic send_req(input logic do_ev, input logic do_uc,
                          input logic [PADDR_W-1:0] ev_addr, input logic [LINE_W-1:0] ev_data,
                          input logic [PADDR_W-1:0] uc_addr, input logic [XLEN_W-1:0] uc_data,
                          input store_size_t size);
    int cycles;
    cycles = 0;
    @(posedge i_clk);
    i_evict_valid <= do_ev;
    i_evict_paddr <= ev_addr;
    i_evict_data  <= ev_data;
    i_uc_valid    <= do_uc;
    i_uc_paddr    <= uc_addr;
    i_uc_data     <= uc_data;
    i_uc_size     <= size;
    @(negedge i_clk);
    while ((do_ev && !o_evict_ready) || (do_uc && !o_uc_ready)) begin
      if (cycles == WAIT_LIMIT) abort_run("store-out input never became ready");
      cycles++;
      @(negedge i_clk);
    end
    @(posedge i_clk);   // transfer edge
    i_evict_valid <= 1'b0;
    i_uc_valid    <= 1'b0;
  endtask

  // stalls ready, then LFSR decides; payload checked every cycle
  task automatic drain_l2(input logic from_uc, input int stall,
                          input logic [PADDR_W-1:0] exp_addr,
                          input logic [LINE_B_W-1:0] exp_be, input logic [LINE_W-1:0] exp_data);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
      if (cycles == WAIT_LIMIT) abort_run("L2 write request never completed");
      @(posedge i_clk);
      if (cycles < stall) begin
        i_l2_ready <= 1'b0;
      end else begin
        lfsr = lfsr_next(lfsr);
        i_l2_ready <= lfsr[0];
      end
      @(negedge i_clk);
      cycles++;
      check_bit("o_l2_valid", o_l2_valid, 1'b1);
      if (from_uc)
        check_bit("o_uc_ready while pending", o_uc_ready, 1'b0);
      else
        check_bit("o_evict_ready while pending", o_evict_ready, 1'b0);
      check_l2_req(CMD_WR, exp_addr, exp_be, exp_data);
      done = i_l2_ready | ~o_l2_valid;
    end
    @(posedge i_clk);   // handshake edge
    i_l2_ready <= 1'b0;
  endtask

  task automatic run_test(input int n, input string op,
                          input logic [PADDR_W-1:0] a0, input logic [LINE_W-1:0] d0,
                          input logic [PADDR_W-1:0] a1, input logic [XLEN_W-1:0] d1,
                          input int size, input int stall,
                          input logic [LINE_B_W-1:0] exp_be, input logic [LINE_W-1:0] exp_data);
    int                  hit_port;
    logic [LINE_B_W-1:0] full_be;
    hit_port = n % LSU_PORT_NUM;
    full_be  = '1;   // evictions write the whole line
    case (op)
      "EVICT", "UC", "BOTH": begin
        send_req(op != "UC", op != "EVICT", a0, d0, a1, d1, store_size_t'(size));
        @(negedge i_clk);
        check_bit("o_l2_valid one cycle after accept", o_l2_valid, 1'b1);
        if (op == "UC") begin
          drain_l2(1'b1, stall, a1, exp_be, exp_data);
        end else if (op == "EVICT") begin
          drain_l2(1'b0, stall, a0, exp_be, exp_data);
        end else begin
          drain_l2(1'b0, stall, a0, full_be, d0);
          @(negedge i_clk);   // UC shows right after the eviction left
          check_bit("o_evict_ready after eviction", o_evict_ready, 1'b1);
          check_bit("UC request follows eviction", o_l2_valid && o_l2_addr == a1, 1'b1);
          drain_l2(1'b1, stall, a1, exp_be, exp_data);
        end
      end
      "FWD": begin
        send_req(1'b1, 1'b0, a0, d0, '0, '0, SIZE_B);
        @(posedge i_clk);
        for (int p = 0; p < LSU_PORT_NUM; p++) begin
          i_fwd_valid[p] <= 1'b1;
          i_fwd_paddr[p] <= (p == hit_port) ? a1 : (a0 ^ 32'h0000_0100);
        end
        @(negedge i_clk);
        for (int p = 0; p < LSU_PORT_NUM; p++) begin
          if (p == hit_port)
            check_fwd(p, |exp_be[XLEN_B_W-1:0], exp_be[XLEN_B_W-1:0], exp_data[XLEN_W-1:0]);
          else
            check_fwd(p, 1'b0, '0, '0);   // other line
        end
        drain_l2(1'b0, stall, a0, full_be, d0);
        @(negedge i_clk);
        for (int p = 0; p < LSU_PORT_NUM; p++)
          check_fwd(p, 1'b0, '0, '0);     // buffer empty now
        @(posedge i_clk);
        for (int p = 0; p < LSU_PORT_NUM; p++)
          i_fwd_valid[p] <= 1'b0;
      end
      "SNOOP": begin
        send_req(1'b1, 1'b0, a0, d0, '0, '0, SIZE_B);
        @(posedge i_clk);
        i_snp_req_valid <= 1'b1;
        i_snp_paddr     <= a1;
        @(negedge i_clk);
        check_bit("o_snp_resp_valid before response cycle", o_snp_resp_valid, 1'b0);
        @(posedge i_clk);
        i_snp_req_valid <= 1'b0;
        @(negedge i_clk);
        check_snoop(exp_be, exp_data);
        drain_l2(1'b0, stall, a0, full_be, d0);
        i_snp_req_valid <= 1'b1;   // again with nothing held
        @(posedge i_clk);
        i_snp_req_valid <= 1'b0;
        @(negedge i_clk);
        check_snoop('0, '0);
      end
      default: begin
        $display("test %0d has an unknown operation %s", n, op);
        err_count++;
      end
    endcase
    check_idle();
  endtask

  initial begin
    int                  fd;
    int                  n;
    int                  cnt;
    int                  size;
    int                  stall;
    int                  errs_before;
    string               line;
    string               op;
    logic [PADDR_W-1:0]  a0;
    logic [PADDR_W-1:0]  a1;
    logic [LINE_W-1:0]   d0;
    logic [XLEN_W-1:0]   d1;
    logic [LINE_B_W-1:0] exp_be;
    logic [LINE_W-1:0]   exp_data;

    i_reset_n       = 1'b0;
    i_evict_valid   = 1'b0;
    i_evict_paddr   = '0;
    i_evict_data    = '0;
    i_uc_valid      = 1'b0;
    i_uc_paddr      = '0;
    i_uc_data       = '0;
    i_uc_size       = SIZE_B;
    i_l2_ready      = 1'b0;
    i_snp_req_valid = 1'b0;
    i_snp_paddr     = '0;
    for (int p = 0; p < LSU_PORT_NUM; p++) begin
      i_fwd_valid[p] = 1'b0;
      i_fwd_paddr[p] = '0;
    end
    lfsr       = 32'h1225;
    err_count  = 0;
    pass_count = 0;
    fail_count = 0;

    repeat (4) @(posedge i_clk);
    i_reset_n <= 1'b1;
    errs_before = err_count;
    check_idle();   // state right after reset
    log_result(0, "RESET", errs_before);

    fd = $fopen("testbench/store_tests.txt", "r");
    if (fd == 0) begin
      abort_run("could not open testbench/store_tests.txt");
    end else begin
      n = 0;
      while (!$feof(fd)) begin
        cnt = $fgets(line, fd);
        if (cnt == 0 || line.len() < 2 || line.getc(0) == "#") continue;
        cnt = $sscanf(line, "%s %h %h %h %h %d %d %h %h",
                      op, a0, d0, a1, d1, size, stall, exp_be, exp_data);
        if (cnt != 9) begin
          $display("test file line could not be parsed: %s", line);
          fail_count++;
          continue;
        end
        n++;
        errs_before = err_count;
        run_test(n, op, a0, d0, a1, d1, size, stall, exp_be, exp_data);
        log_result(n, op, errs_before);
      end
      $fclose(fd);

      $display("%0d tests run, %0d passed, %0d failed", pass_count + fail_count,
               pass_count, fail_count);
      if (fail_count == 0 && n > 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
      $finish;
    end
  end

endmodule

// ==== testbench/store_tests.txt ====
# op addr0 data0 addr1 data1 size stall exp_be exp_data (hex, size and stall decimal)
# EVICT: addr0/data0, UC: addr1/data1/size, BOTH: all with UC expect, FWD/SNOOP: probe at addr1
EVICT 80001000 00112233445566778899aabbccddeeff 0 0 0 0 ffff 00112233445566778899aabbccddeeff
EVICT 80001040 0f0e0d0c0b0a09080706050403020100 0 0 0 3 ffff 0f0e0d0c0b0a09080706050403020100
EVICT 9abc0000 deadbeefcafef00d0123456789abcdef 0 0 0 7 ffff deadbeefcafef00d0123456789abcdef
EVICT 7ffffff0 ffffffffffffffffffffffffffffffff 0 0 0 12 ffff ffffffffffffffffffffffffffffffff
UC 0 0 10000003 a5 0 0 0008 a5000000
UC 0 0 1000000f 5a 0 1 8000 5a000000000000000000000000000000
UC 0 0 10000006 beef 1 0 00c0 beef000000000000
UC 0 0 1000000a 1234 1 2 0c00 123400000000000000000000
UC 0 0 10000004 c0ffee11 2 0 00f0 c0ffee1100000000
UC 0 0 1000000c 89abcdef 2 4 f000 89abcdef000000000000000000000000
UC 0 0 10000000 0123456789abcdef 3 0 00ff 0123456789abcdef
UC 0 0 10000008 fedcba9876543210 3 5 ff00 fedcba98765432100000000000000000
UC 0 0 20000002 7788 1 1 000c 77880000
UC 0 0 20000001 42 0 9 0002 4200
BOTH 30000000 0f1e2d3c4b5a6978 30000108 55667788 2 2 0f00 556677880000000000000000
BOTH 30000040 0123456789abcdeffedcba9876543210 30000042 abcd 1 6 000c abcd0000
BOTH 30000080 ffffffff000000001111111122222222 30000084 12345678 2 0 00f0 1234567800000000
BOTH 31000000 5a5a5a5a 31000003 e7 0 3 0008 e7000000
FWD 40000000 00112233445566778899aabbccddeeff 40000000 0 0 0 ff 8899aabbccddeeff
FWD 40000000 00112233445566778899aabbccddeeff 40000008 0 0 2 ff 0011223344556677
FWD 40000000 00112233445566778899aabbccddeeff 40000004 0 0 1 ff 445566778899aabb
FWD 40000000 00112233445566778899aabbccddeeff 4000000d 0 0 0 ff 1122
FWD 40000000 00112233445566778899aabbccddeeff 40000010 0 0 0 00 0
FWD 40000000 00112233445566778899aabbccddeeff 50000000 0 0 4 00 0
FWD 40001230 cafebabe12345678deadbeef87654321 40001232 0 0 3 ff 5678deadbeef8765
SNOOP 60000000 2468ace013579bdf00ff 60000000 0 0 0 ffff 2468ace013579bdf00ff
SNOOP 60000000 2468ace013579bdf00ff 6000000f 0 0 2 ffff 2468ace013579bdf00ff
SNOOP 60000000 2468ace013579bdf00ff 60000010 0 0 0 0000 0
SNOOP 6abc0040 ffffffff00000000ffffffff 6abc0048 0 0 5 ffff ffffffff00000000ffffffff
SNOOP 6abc0040 ffffffff00000000ffffffff 7abc0040 0 0 1 0000 0

// ==== compile.f ====
hdl/stout_pkg.sv
hdl/evict_buffer.sv
hdl/uc_store_buffer.sv
hdl/l2_write_arbiter.sv
hdl/lsu_fwd_checker.sv
hdl/snoop_responder.sv
hdl/store_requestor.sv
testbench/tb_store_requestor.sv

// ==== run.sh ====
#!/bin/sh
# build the store-out testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_store_requestor -o tb_store_requestor -f compile.f \
  && ./obj_dir/tb_store_requestor | tee /dev/stderr | grep -qx "TEST PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
